//--- Makefile
# Verilator build and run of the wormhole to DMA bridge testbench

VERILATOR ?= verilator
TOP       ?= wh_dma_fanout_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard include/*.svh source/*.sv verification/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+include
source/wh_dma_pkg.sv
source/small_fifo.sv
source/rr_arbiter.sv
source/route_queue.sv
source/wh_dma_ctrl.sv
source/wh_dma_fanout.sv
verification/wh_dma_fanout_assertions.sv
verification/wh_dma_fanout_tb.sv

//--- include/wh_dma_params.svh
/*
  widths, channel count, burst length and queue depths of the wormhole to DMA bridge
*/
`ifndef WH_DMA_PARAMS_SVH
`define WH_DMA_PARAMS_SVH

// link flit and DMA data beat share one width
`define WH_FLIT_WIDTH 32
// DMA byte address
`define DMA_ADDR_WIDTH 28

`define NUM_DMA 4

// header flit fields
`define WH_CORD_WIDTH 8
`define WH_CID_WIDTH 2
`define WH_LEN_WIDTH 4

// data beats in every DMA transfer
`define BURST_LEN 4

// outstanding reads per channel
`define ROUTE_DEPTH 4
`define IN_FIFO_DEPTH 2

`endif

//--- source/route_queue.sv
/*
  per-channel queues of return routes, one small FIFO per channel
*/
`include "wh_dma_params.svh"

module route_queue
  import wh_dma_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    push_v_i,
  input  dma_id_t push_id_i,
  input  route_t  push_route_i,
  output logic    push_ready_o,
  input  logic    pop_i,
  input  dma_id_t pop_id_i,
  output route_t  head_route_o
);

  logic [`NUM_DMA-1:0] fifo_v_in;
  logic [`NUM_DMA-1:0] fifo_ready;
  logic [`NUM_DMA-1:0] fifo_pop;
  route_t fifo_head [`NUM_DMA];

  for (genvar i = 0; i < `NUM_DMA; i++) begin : g_chan
    // steer push and pop to the addressed channel only
    assign fifo_v_in[i] = push_v_i & (push_id_i == dma_id_t'(i));
    assign fifo_pop[i] = pop_i & (pop_id_i == dma_id_t'(i));

    small_fifo #(
      .elem_t(route_t),
      .DEPTH (`ROUTE_DEPTH)
    ) route_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (fifo_v_in[i]),
      .data_i (push_route_i),
      .ready_o(fifo_ready[i]),
      .v_o    (),
      .data_o (fifo_head[i]),
      .ready_i(fifo_pop[i])
    );
  end

  assign push_ready_o = fifo_ready[push_id_i];
  // head of the channel currently being returned
  assign head_route_o = fifo_head[pop_id_i];

endmodule

//--- source/rr_arbiter.sv
/*
  round-robin arbiter over the channel fill requests
*/
`include "wh_dma_params.svh"

module rr_arbiter
  import wh_dma_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [`NUM_DMA-1:0] reqs_i,
  input  logic               accept_i,
  output logic               v_o,
  output dma_id_t            grant_id_o
);

  dma_id_t last_r;
  dma_id_t idx;
  logic found;

  assign v_o = |reqs_i;

  // search starts just after the last granted channel
  always_comb begin
    grant_id_o = last_r;
    found = 1'b0;
    idx = last_r;
    for (int i = 1; i <= `NUM_DMA; i++) begin
      idx = dma_id_t'((int'(last_r) + i) % `NUM_DMA);
      if (!found && reqs_i[idx]) begin
        grant_id_o = idx;
        found = 1'b1;
      end
    end
  end

  // channel 0 gets first pick after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= dma_id_t'(`NUM_DMA-1);
    end else if (accept_i & v_o) begin
      last_r <= grant_id_o;
    end
  end

endmodule

//--- source/small_fifo.sv
/*
  small valid/ready FIFO, circular buffer with a count register
*/
`include "wh_dma_params.svh"

module small_fifo
  import wh_dma_pkg::*;
#(
  parameter type elem_t = flit_t,
  parameter int DEPTH = `IN_FIFO_DEPTH
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  v_i,
  input  elem_t data_i,
  output logic  ready_o,
  output logic  v_o,
  output elem_t data_o,
  input  logic  ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  elem_t mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r, rd_ptr_r;
  logic [PTR_W:0] count_r;
  logic push, pop;

  assign ready_o = (count_r != (PTR_W+1)'(DEPTH));
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];
  assign push = v_i & ready_o;
  assign pop = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // count moves only when exactly one side transfers
      if (push & ~pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop & ~push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- source/wh_dma_ctrl.sv
/*
  send and return FSMs of the bridge, with their beat counters
*/
`include "wh_dma_params.svh"

module wh_dma_ctrl
  import wh_dma_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     head_v_i,
  input  flit_t                    head_flit_i,
  output logic                     head_pop_o,
  input  dma_id_t                  wh_dma_id_i,
  output logic [`NUM_DMA-1:0]      dma_pkt_v_o,
  output dma_pkt_t [`NUM_DMA-1:0]  dma_pkt_o,
  input  logic [`NUM_DMA-1:0]      dma_pkt_ready_i,
  output logic [`NUM_DMA-1:0]      dma_wdata_v_o,
  output flit_t [`NUM_DMA-1:0]     dma_wdata_o,
  input  logic [`NUM_DMA-1:0]      dma_wdata_ready_i,
  input  logic [`NUM_DMA-1:0]      dma_rdata_v_i,
  input  flit_t [`NUM_DMA-1:0]     dma_rdata_i,
  output logic [`NUM_DMA-1:0]      dma_rdata_ready_o,
  output logic                     route_push_v_o,
  output dma_id_t                  route_push_id_o,
  output route_t                   route_o,
  input  logic                     route_push_ready_i,
  output logic                     route_pop_o,
  output dma_id_t                  route_pop_id_o,
  input  route_t                   route_head_i,
  input  logic                     arb_v_i,
  input  dma_id_t                  arb_grant_i,
  output logic                     arb_accept_o,
  output logic                     link_out_v_o,
  output flit_t                    link_out_data_o,
  input  logic                     link_out_ready_i
);

  localparam int CNT_W = ($clog2(`BURST_LEN) > 0) ? $clog2(`BURST_LEN) : 1;

  typedef enum logic [1:0] {SEND_IDLE, SEND_PKT, SEND_EVICT} send_state_e;
  typedef enum logic [1:0] {RET_IDLE, RET_HEADER, RET_FILL} ret_state_e;

  send_state_e send_state_r, send_state_n;
  ret_state_e ret_state_r, ret_state_n;
  logic wnr_r;
  route_t route_r;
  dma_id_t send_id_r;
  dma_id_t ret_id_r;
  logic [CNT_W-1:0] send_cnt_r, ret_cnt_r;
  logic send_beat, ret_beat;
  logic send_last, ret_last;
  header_flit_t hdr_in, hdr_out;
  dma_pkt_t pkt;

  assign hdr_in = header_flit_t'(head_flit_i);
  assign send_last = (send_cnt_r == CNT_W'(`BURST_LEN-1));
  assign ret_last = (ret_cnt_r == CNT_W'(`BURST_LEN-1));

  // packet and eviction data go to every channel and only the chosen one sees valid
  assign pkt.write_not_read = wnr_r;
  assign pkt.addr = head_flit_i[`DMA_ADDR_WIDTH-1:0];
  assign dma_pkt_o = {`NUM_DMA{pkt}};
  assign dma_wdata_o = {`NUM_DMA{head_flit_i}};

  assign route_push_id_o = send_id_r;
  assign route_o = route_r;
  assign route_pop_id_o = ret_id_r;

  always_comb begin
    send_state_n = send_state_r;
    head_pop_o = 1'b0;
    dma_pkt_v_o = '0;
    dma_wdata_v_o = '0;
    route_push_v_o = 1'b0;
    send_beat = 1'b0;
    unique case (send_state_r)
      SEND_IDLE: begin
        if (head_v_i) begin
          head_pop_o = 1'b1;
          send_state_n = SEND_PKT;
        end
      end
      SEND_PKT: begin
        // a read waits here until its channel has room for the route
        dma_pkt_v_o[send_id_r] = head_v_i & (wnr_r | route_push_ready_i);
        if (dma_pkt_v_o[send_id_r] & dma_pkt_ready_i[send_id_r]) begin
          head_pop_o = 1'b1;
          route_push_v_o = ~wnr_r;
          send_state_n = wnr_r ? SEND_EVICT : SEND_IDLE;
        end
      end
      SEND_EVICT: begin
        dma_wdata_v_o[send_id_r] = head_v_i;
        if (head_v_i & dma_wdata_ready_i[send_id_r]) begin
          head_pop_o = 1'b1;
          send_beat = 1'b1;
          if (send_last) begin
            send_state_n = SEND_IDLE;
          end
        end
      end
      default: begin
        send_state_n = SEND_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= SEND_IDLE;
      send_cnt_r <= '0;
    end else begin
      send_state_r <= send_state_n;
      if (send_beat) begin
        send_cnt_r <= send_last ? '0 : send_cnt_r + 1'b1;
      end
    end
  end

  // header fields are captured as the header leaves the buffer
  always_ff @(posedge clk_i) begin
    if (send_state_r == SEND_IDLE && head_v_i) begin
      wnr_r <= hdr_in.write_not_read;
      route_r.cid <= hdr_in.cid;
      route_r.cord <= hdr_in.src_cord;
      send_id_r <= wh_dma_id_i;
    end
  end

  // return header carries no source coordinate since the bridge has none
  assign hdr_out.unused = '0;
  assign hdr_out.write_not_read = 1'b0;
  assign hdr_out.len = `WH_LEN_WIDTH'(`BURST_LEN);
  assign hdr_out.src_cord = '0;
  assign hdr_out.dest_cord = route_head_i.cord;
  assign hdr_out.cid = route_head_i.cid;

  always_comb begin
    ret_state_n = ret_state_r;
    arb_accept_o = 1'b0;
    link_out_v_o = 1'b0;
    link_out_data_o = flit_t'(hdr_out);
    dma_rdata_ready_o = '0;
    route_pop_o = 1'b0;
    ret_beat = 1'b0;
    unique case (ret_state_r)
      RET_IDLE: begin
        if (arb_v_i) begin
          arb_accept_o = 1'b1;
          ret_state_n = RET_HEADER;
        end
      end
      RET_HEADER: begin
        link_out_v_o = 1'b1;
        if (link_out_ready_i) begin
          ret_state_n = RET_FILL;
        end
      end
      RET_FILL: begin
        link_out_v_o = dma_rdata_v_i[ret_id_r];
        link_out_data_o = dma_rdata_i[ret_id_r];
        dma_rdata_ready_o[ret_id_r] = link_out_ready_i;
        if (dma_rdata_v_i[ret_id_r] & link_out_ready_i) begin
          ret_beat = 1'b1;
          // route is done with after the last fill beat
          if (ret_last) begin
            route_pop_o = 1'b1;
            ret_state_n = RET_IDLE;
          end
        end
      end
      default: begin
        ret_state_n = RET_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ret_state_r <= RET_IDLE;
      ret_cnt_r <= '0;
    end else begin
      ret_state_r <= ret_state_n;
      if (ret_beat) begin
        ret_cnt_r <= ret_last ? '0 : ret_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (arb_accept_o) begin
      ret_id_r <= arb_grant_i;
    end
  end

endmodule

//--- source/wh_dma_fanout.sv
/*
  top level of the wormhole link to DMA channel bridge
*/
`include "wh_dma_params.svh"

module wh_dma_fanout
  import wh_dma_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  // inbound link
  input  logic                     link_in_v_i,
  input  flit_t                    link_in_data_i,
  output logic                     link_in_ready_o,
  input  dma_id_t                  wh_dma_id_i,
  // outbound link
  output logic                     link_out_v_o,
  output flit_t                    link_out_data_o,
  input  logic                     link_out_ready_i,
  // DMA channels
  output logic [`NUM_DMA-1:0]      dma_pkt_v_o,
  output dma_pkt_t [`NUM_DMA-1:0]  dma_pkt_o,
  input  logic [`NUM_DMA-1:0]      dma_pkt_ready_i,
  output logic [`NUM_DMA-1:0]      dma_wdata_v_o,
  output flit_t [`NUM_DMA-1:0]     dma_wdata_o,
  input  logic [`NUM_DMA-1:0]      dma_wdata_ready_i,
  input  logic [`NUM_DMA-1:0]      dma_rdata_v_i,
  input  flit_t [`NUM_DMA-1:0]     dma_rdata_i,
  output logic [`NUM_DMA-1:0]      dma_rdata_ready_o
);

  logic head_v;
  flit_t head_flit;
  logic head_pop;
  logic route_push_v;
  dma_id_t route_push_id;
  route_t route;
  logic route_push_ready;
  logic route_pop;
  dma_id_t route_pop_id;
  route_t route_head;
  logic arb_v;
  dma_id_t arb_grant;
  logic arb_accept;

  small_fifo #(
    .elem_t(flit_t),
    .DEPTH (`IN_FIFO_DEPTH)
  ) in_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (link_in_v_i),
    .data_i (link_in_data_i),
    .ready_o(link_in_ready_o),
    .v_o    (head_v),
    .data_o (head_flit),
    .ready_i(head_pop)
  );

  wh_dma_ctrl ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .head_v_i          (head_v),
    .head_flit_i       (head_flit),
    .head_pop_o        (head_pop),
    .wh_dma_id_i       (wh_dma_id_i),
    .dma_pkt_v_o       (dma_pkt_v_o),
    .dma_pkt_o         (dma_pkt_o),
    .dma_pkt_ready_i   (dma_pkt_ready_i),
    .dma_wdata_v_o     (dma_wdata_v_o),
    .dma_wdata_o       (dma_wdata_o),
    .dma_wdata_ready_i (dma_wdata_ready_i),
    .dma_rdata_v_i     (dma_rdata_v_i),
    .dma_rdata_i       (dma_rdata_i),
    .dma_rdata_ready_o (dma_rdata_ready_o),
    .route_push_v_o    (route_push_v),
    .route_push_id_o   (route_push_id),
    .route_o           (route),
    .route_push_ready_i(route_push_ready),
    .route_pop_o       (route_pop),
    .route_pop_id_o    (route_pop_id),
    .route_head_i      (route_head),
    .arb_v_i           (arb_v),
    .arb_grant_i       (arb_grant),
    .arb_accept_o      (arb_accept),
    .link_out_v_o      (link_out_v_o),
    .link_out_data_o   (link_out_data_o),
    .link_out_ready_i  (link_out_ready_i)
  );

  route_queue route_q (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_v_i    (route_push_v),
    .push_id_i   (route_push_id),
    .push_route_i(route),
    .push_ready_o(route_push_ready),
    .pop_i       (route_pop),
    .pop_id_i    (route_pop_id),
    .head_route_o(route_head)
  );

  rr_arbiter arb (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .reqs_i    (dma_rdata_v_i),
    .accept_i  (arb_accept),
    .v_o       (arb_v),
    .grant_id_o(arb_grant)
  );

endmodule

//--- source/wh_dma_pkg.sv
/*
  flit, header flit, DMA packet and return route types
*/
`include "wh_dma_params.svh"

package wh_dma_pkg;

  typedef logic [`WH_FLIT_WIDTH-1:0] flit_t;

  typedef logic [$clog2(`NUM_DMA)-1:0] dma_id_t;

  // header layout with cid in the low bits
  typedef struct packed {
    logic [`WH_FLIT_WIDTH-2-`WH_LEN_WIDTH-2*`WH_CORD_WIDTH-`WH_CID_WIDTH:0] unused;
    logic write_not_read;
    logic [`WH_LEN_WIDTH-1:0] len;
    logic [`WH_CORD_WIDTH-1:0] src_cord;
    logic [`WH_CORD_WIDTH-1:0] dest_cord;
    logic [`WH_CID_WIDTH-1:0] cid;
  } header_flit_t;

  typedef struct packed {
    logic write_not_read;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

  // where the fill of one read has to go back to
  typedef struct packed {
    logic [`WH_CID_WIDTH-1:0] cid;
    logic [`WH_CORD_WIDTH-1:0] cord;
  } route_t;

endpackage

//--- verification/wh_dma_fanout_assertions.sv
/*
  concurrent assertions on the handshakes of the bridge top level
*/
`include "wh_dma_params.svh"

module wh_dma_fanout_assertions
  import wh_dma_pkg::*;
(
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    link_out_v_o,
  input flit_t                   link_out_data_o,
  input logic                    link_out_ready_i,
  input logic [`NUM_DMA-1:0]     dma_pkt_v_o,
  input dma_pkt_t [`NUM_DMA-1:0] dma_pkt_o,
  input logic [`NUM_DMA-1:0]     dma_pkt_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled outbound flit keeps valid and data
  link_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    link_out_v_o && !link_out_ready_i |=> link_out_v_o && $stable(link_out_data_o))
    else $error("outbound flit changed while stalled");

  // a stalled DMA packet keeps its channel and contents
  pkt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    |(dma_pkt_v_o & ~dma_pkt_ready_i) |=> $stable(dma_pkt_v_o) && $stable(dma_pkt_o))
    else $error("DMA packet changed while stalled");

  pkt_one_channel: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(dma_pkt_v_o))
    else $error("DMA packet valid on more than one channel");

endmodule

bind wh_dma_fanout wh_dma_fanout_assertions wh_dma_fanout_assertions_i (.*);

//--- verification/wh_dma_fanout_tb.sv
/*
  testbench of the wormhole to DMA bridge with channel memory models,
  stimulus, reference function and compare process
*/
`include "wh_dma_params.svh"

module wh_dma_fanout_tb
  import wh_dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 2000;
  localparam int LOW_W = `WH_FLIT_WIDTH - $clog2(`NUM_DMA);

  logic clk_i = 1'b0;
  logic reset_i;
  logic link_in_v_i;
  flit_t link_in_data_i;
  logic link_in_ready_o;
  dma_id_t wh_dma_id_i;
  logic link_out_v_o;
  flit_t link_out_data_o;
  logic link_out_ready_i = 1'b1;
  logic [`NUM_DMA-1:0] dma_pkt_v_o;
  dma_pkt_t [`NUM_DMA-1:0] dma_pkt_o;
  logic [`NUM_DMA-1:0] dma_pkt_ready_i = '1;
  logic [`NUM_DMA-1:0] dma_wdata_v_o;
  flit_t [`NUM_DMA-1:0] dma_wdata_o;
  logic [`NUM_DMA-1:0] dma_wdata_ready_i = '1;
  logic [`NUM_DMA-1:0] dma_rdata_v_i = '0;
  flit_t [`NUM_DMA-1:0] dma_rdata_i = '0;
  logic [`NUM_DMA-1:0] dma_rdata_ready_o;

  string test_name = "reset";
  logic rand_mode = 1'b0;
  // channels keep their fills back while set
  logic fill_hold = 1'b0;
  int pkt_count = 0;
  int next_cord = 1;

  // expected traffic queues per channel and for the outbound link
  dma_pkt_t exp_pkt_q [`NUM_DMA][$];
  flit_t exp_wdata_q [`NUM_DMA][$];
  route_t exp_route_q [`NUM_DMA][$];
  logic [`DMA_ADDR_WIDTH-1:0] exp_addr_q [`NUM_DMA][$];
  flit_t exp_flit_q [$];

  // memory model state
  logic [`DMA_ADDR_WIDTH-1:0] fill_addr_q [`NUM_DMA][$];
  int fill_beat [`NUM_DMA] = '{default: 0};
  int beats_done [`NUM_DMA] = '{default: 0};
  int beats_offered [`NUM_DMA] = '{default: 0};

  wh_dma_fanout wh_dma_fanout_i (.*);

  always #50 clk_i = ~clk_i;

  // fill beat k of a read at address a on channel c
  function automatic flit_t expected_fill(logic [`DMA_ADDR_WIDTH-1:0] a, dma_id_t c, int k);
    logic [LOW_W-1:0] low;
    low = LOW_W'(a) + LOW_W'(k);
    return {c, low};
  endfunction

  function automatic logic drained();
    logic empty;
    empty = (exp_flit_q.size() == 0);
    for (int c = 0; c < `NUM_DMA; c++) begin
      empty &= (exp_pkt_q[c].size() == 0) && (exp_wdata_q[c].size() == 0);
      empty &= (exp_route_q[c].size() == 0) && (fill_addr_q[c].size() == 0);
    end
    return empty;
  endfunction

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_header(header_flit_t exp, header_flit_t act);
    if (act.dest_cord !== exp.dest_cord || act.cid !== exp.cid ||
        act.len !== exp.len || act.write_not_read !== exp.write_not_read) begin
      stop_with_error($sformatf("FAILED %s: header expected %h, actual %h",
                                test_name, exp, act));
    end
  endtask

  task automatic check_pkt(dma_pkt_t exp, dma_pkt_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("FAILED %s: packet expected %h, actual %h",
                                test_name, exp, act));
    end
  endtask

  task automatic check_data(flit_t exp, flit_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("FAILED %s: data expected %h, actual %h",
                                test_name, exp, act));
    end
  endtask

  // compare process that sees every transfer at the rising edge
  always @(posedge clk_i) begin : monitor
    header_flit_t hdr;
    header_flit_t exp_hdr;
    int ch;
    if (!reset_i) begin
      for (int c = 0; c < `NUM_DMA; c++) begin
        if (dma_pkt_v_o[c] && dma_pkt_ready_i[c]) begin
          if (exp_pkt_q[c].size() == 0) begin
            stop_with_error($sformatf("%s: channel %0d got a packet nobody sent",
                                      test_name, c));
          end else begin
            check_pkt(exp_pkt_q[c].pop_front(), dma_pkt_o[c]);
            if (!dma_pkt_o[c].write_not_read) begin
              fill_addr_q[c].push_back(dma_pkt_o[c].addr);
            end
            pkt_count++;
          end
        end
        if (dma_wdata_v_o[c] && dma_wdata_ready_i[c]) begin
          if (exp_wdata_q[c].size() == 0) begin
            stop_with_error($sformatf("%s: channel %0d got an eviction beat too many",
                                      test_name, c));
          end else begin
            check_data(exp_wdata_q[c].pop_front(), dma_wdata_o[c]);
          end
        end
        if (dma_rdata_v_i[c] && dma_rdata_ready_o[c]) begin
          beats_done[c]++;
          if (fill_beat[c] == `BURST_LEN-1) begin
            fill_beat[c] = 0;
            void'(fill_addr_q[c].pop_front());
          end else begin
            fill_beat[c]++;
          end
        end
      end
      if (link_out_v_o && link_out_ready_i) begin
        if (exp_flit_q.size() > 0) begin
          check_data(exp_flit_q.pop_front(), link_out_data_o);
        end else begin
          hdr = header_flit_t'(link_out_data_o);
          ch = -1;
          // distinct sender coordinates let the oldest read per channel identify the header
          for (int c = 0; c < `NUM_DMA; c++) begin
            if (ch < 0 && exp_route_q[c].size() > 0 &&
                exp_route_q[c][0].cord == hdr.dest_cord) begin
              ch = c;
            end
          end
          for (int c = 0; c < `NUM_DMA; c++) begin
            if (ch < 0 && exp_route_q[c].size() > 0) begin
              ch = c;
            end
          end
          if (ch < 0) begin
            stop_with_error($sformatf("%s: outbound flit %h while no read was outstanding",
                                      test_name, link_out_data_o));
          end else begin
            exp_hdr = '0;
            exp_hdr.len = `WH_LEN_WIDTH'(`BURST_LEN);
            exp_hdr.dest_cord = exp_route_q[ch][0].cord;
            exp_hdr.cid = exp_route_q[ch][0].cid;
            check_header(exp_hdr, hdr);
            for (int k = 0; k < `BURST_LEN; k++) begin
              exp_flit_q.push_back(expected_fill(exp_addr_q[ch][0], dma_id_t'(ch), k));
            end
            void'(exp_route_q[ch].pop_front());
            void'(exp_addr_q[ch].pop_front());
          end
        end
      end
    end
  end

  // channel memory models and outbound ready driven on the falling edge
  always @(negedge clk_i) begin : channel_driver
    for (int c = 0; c < `NUM_DMA; c++) begin
      dma_pkt_ready_i[c] = !rand_mode || ($urandom % 4 != 0);
      dma_wdata_ready_i[c] = !rand_mode || ($urandom % 4 != 0);
      // a raised fill beat stays until it is taken
      if (!(dma_rdata_v_i[c] && beats_done[c] < beats_offered[c])) begin
        if (!fill_hold && fill_addr_q[c].size() > 0 && (!rand_mode || $urandom % 3 != 0)) begin
          dma_rdata_v_i[c] = 1'b1;
          dma_rdata_i[c] = {dma_id_t'(c), LOW_W'(fill_addr_q[c][0]) + LOW_W'(fill_beat[c])};
          beats_offered[c]++;
        end else begin
          dma_rdata_v_i[c] = 1'b0;
        end
      end
    end
    link_out_ready_i = !rand_mode || ($urandom % 4 != 0);
  end

  task automatic send_flit(flit_t f);
    int waited;
    logic taken;
    if (rand_mode) begin
      repeat ($urandom % 3) @(negedge clk_i);
    end
    link_in_v_i = 1'b1;
    link_in_data_i = f;
    waited = 0;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = link_in_ready_o;
      @(negedge clk_i);
      waited++;
      if (!taken && waited > TIMEOUT) begin
        stop_with_error($sformatf("%s: inbound link never accepted a flit", test_name));
      end
    end
    link_in_v_i = 1'b0;
  endtask

  task automatic wait_packets(int target);
    int waited;
    waited = 0;
    while (pkt_count < target) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_error($sformatf("%s: DMA packet never issued", test_name));
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!drained()) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_error($sformatf("%s: outstanding traffic did not complete", test_name));
      end
    end
  endtask

  task automatic send_packet(dma_id_t c, logic wnr, logic [`WH_CID_WIDTH-1:0] cid,
                             logic [`DMA_ADDR_WIDTH-1:0] addr);
    header_flit_t hdr;
    route_t r;
    flit_t beats [`BURST_LEN];
    int target;
    hdr = '0;
    hdr.write_not_read = wnr;
    hdr.len = `WH_LEN_WIDTH'(`BURST_LEN);
    hdr.src_cord = `WH_CORD_WIDTH'(next_cord);
    hdr.cid = cid;
    next_cord = (next_cord + 1) % 256;
    r.cid = cid;
    r.cord = hdr.src_cord;
    target = pkt_count + 1;
    exp_pkt_q[c].push_back(dma_pkt_t'({wnr, addr}));
    if (wnr) begin
      for (int k = 0; k < `BURST_LEN; k++) begin
        beats[k] = $urandom;
        exp_wdata_q[c].push_back(beats[k]);
      end
    end else begin
      exp_route_q[c].push_back(r);
      exp_addr_q[c].push_back(addr);
    end
    // the channel id is sampled with the header
    wh_dma_id_i = c;
    send_flit(flit_t'(hdr));
    send_flit(flit_t'(addr));
    if (wnr) begin
      for (int k = 0; k < `BURST_LEN; k++) begin
        send_flit(beats[k]);
      end
    end
    wait_packets(target);
  endtask

  initial begin : main
    void'($urandom(12398));
    reset_i = 1'b1;
    link_in_v_i = 1'b0;
    link_in_data_i = '0;
    wh_dma_id_i = '0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    if (link_out_v_o || (|dma_pkt_v_o) || (|dma_wdata_v_o) || !link_in_ready_o) begin
      stop_with_error("reset: outputs are not in their idle state after reset");
    end

    test_name = "single_read";
    for (int c = 0; c < `NUM_DMA; c++) begin
      send_packet(dma_id_t'(c), 1'b0, `WH_CID_WIDTH'(c), `DMA_ADDR_WIDTH'($urandom));
      wait_drain();
    end

    test_name = "single_write";
    for (int c = 0; c < `NUM_DMA; c++) begin
      send_packet(dma_id_t'(c), 1'b1, `WH_CID_WIDTH'(c), `DMA_ADDR_WIDTH'($urandom));
      wait_drain();
    end

    // reads queue up on one channel before any fill comes back
    test_name = "ordered_reads";
    fill_hold = 1'b1;
    for (int i = 0; i < `ROUTE_DEPTH; i++) begin
      send_packet(dma_id_t'(2), 1'b0, `WH_CID_WIDTH'(i), `DMA_ADDR_WIDTH'($urandom));
    end
    fill_hold = 1'b0;
    wait_drain();

    test_name = "random_reads";
    rand_mode = 1'b1;
    fill_hold = 1'b1;
    for (int i = 0; i < 3 * `NUM_DMA; i++) begin
      send_packet(dma_id_t'(i % `NUM_DMA), 1'b0, `WH_CID_WIDTH'($urandom),
                  `DMA_ADDR_WIDTH'($urandom));
    end
    fill_hold = 1'b0;
    wait_drain();

    test_name = "random_mixed";
    for (int i = 0; i < 24; i++) begin
      send_packet(dma_id_t'($urandom % `NUM_DMA), 1'($urandom % 2),
                  `WH_CID_WIDTH'($urandom), `DMA_ADDR_WIDTH'($urandom));
    end
    wait_drain();

    $display("NO ERRORS");
    $finish;
  end

endmodule
